/* hw/lsu_pkg.sv */
package lsu_pkg;

    ////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////
    localparam int addr_w      = 8;
    localparam int data_w      = 16;
    localparam int tag_w       = 6;
    localparam int lq_depth    = 8;
    localparam int sq_depth    = 8;
    localparam int ptr_w       = $clog2(lq_depth);
    localparam int mem_latency = 3;
    localparam int lat_w       = $clog2(mem_latency + 1);

    typedef enum logic {op_load, op_store} lsu_op_e;

    typedef enum logic [1:0] {arb_idle, arb_load, arb_store, arb_wait} arb_state_e;

    ////////////////////////////////////////
    // Shared structs
    ////////////////////////////////////////
    typedef struct packed {
        lsu_op_e           op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [tag_w-1:0]  tag;
    } lsu_issue_t;

    typedef struct packed {
        logic              vld;
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } ld_result_t;

    // rd_wrt set means write
    typedef struct packed {
        logic              rd_wrt;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_req_t;

endpackage

/* hw/load_queue.sv */
`timescale 1ns/1ns

module load_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_vld,
    input  lsu_pkg::lsu_issue_t        issue,
    input  logic                       flsh,
    input  logic [lsu_pkg::ptr_w-1:0]  sq_tail,
    input  logic                       fwd_hit,
    input  logic [lsu_pkg::data_w-1:0] fwd_data,
    input  logic                       ld_grnt,
    input  logic                       mem_done,
    input  logic [lsu_pkg::data_w-1:0] rd_data,
    output logic [lsu_pkg::addr_w-1:0] fwd_addr,
    output logic [lsu_pkg::ptr_w-1:0]  fwd_ptr,
    output logic                       ld_req,
    output logic [lsu_pkg::addr_w-1:0] ld_addr,
    output lsu_pkg::ld_result_t        ld_result,
    output logic                       stll
);

    import lsu_pkg::*;

    // snap is the store queue tail seen when the load arrived
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [tag_w-1:0]  tag;
        logic [ptr_w-1:0]  snap;
    } lq_entry_t;

    lq_entry_t      lq_mem [lq_depth];
    lq_entry_t      head_ent;
    logic [ptr_w:0] head;
    logic [ptr_w:0] tail;
    logic           lq_empty;
    logic           lq_full;
    logic           lq_wr;
    logic           head_chk;
    logic           ld_pend;
    logic           ld_busy;

    assign lq_empty = (head == tail);
    assign lq_full  = (head[ptr_w] != tail[ptr_w]) && (head[ptr_w-1:0] == tail[ptr_w-1:0]);
    assign lq_wr    = issue_vld && (issue.op == op_load);
    assign head_ent = lq_mem[head[ptr_w-1:0]];

    // First cycle of a load at the head is its forwarding check
    assign head_chk = !lq_empty && !ld_pend;

    assign stll     = lq_full;
    assign fwd_addr = head_ent.addr;
    assign fwd_ptr  = head_ent.snap;
    assign ld_addr  = head_ent.addr;
    assign ld_req   = ld_pend;

    always_ff @(posedge clk) begin
        if (lq_wr) begin
            lq_mem[tail[ptr_w-1:0]] <= '{addr: issue.addr, tag: issue.tag, snap: sq_tail};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head          <= '0;
            tail          <= '0;
            ld_pend       <= 1'b0;
            ld_busy       <= 1'b0;
            ld_result.vld <= 1'b0;
        end else if (flsh) begin
            // An access already in memory finishes unclaimed
            head          <= tail;
            ld_pend       <= 1'b0;
            ld_busy       <= 1'b0;
            ld_result.vld <= 1'b0;
        end else begin
            ld_result.vld <= 1'b0;
            if (lq_wr) begin
                tail <= tail + 1'b1;
            end
            if (head_chk && fwd_hit) begin
                ld_result.vld  <= 1'b1;
                ld_result.tag  <= head_ent.tag;
                ld_result.data <= fwd_data;
                head           <= head + 1'b1;
            end else if (head_chk) begin
                ld_pend <= 1'b1;
            end
            if (ld_pend && ld_grnt) begin
                ld_busy <= 1'b1;
            end
            if (ld_busy && mem_done) begin
                ld_result.vld  <= 1'b1;
                ld_result.tag  <= head_ent.tag;
                ld_result.data <= rd_data;
                head           <= head + 1'b1;
                ld_pend        <= 1'b0;
                ld_busy        <= 1'b0;
            end
        end
    end

    // Issue is gated by the combined stall in the top level
    assert property (@(posedge clk) disable iff (!rst_n) lq_wr |-> !lq_full);

endmodule

/* hw/store_queue.sv */
`timescale 1ns/1ns

module store_queue (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue_vld,
    input  lsu_pkg::lsu_issue_t        issue,
    input  logic                       cmmt_str,
    input  logic                       flsh,
    input  logic [lsu_pkg::addr_w-1:0] fwd_addr,
    input  logic [lsu_pkg::ptr_w-1:0]  fwd_ptr,
    input  logic                       str_grnt,
    input  logic                       mem_done,
    output logic [lsu_pkg::ptr_w-1:0]  sq_tail,
    output logic                       fwd_hit,
    output logic [lsu_pkg::data_w-1:0] fwd_data,
    output logic                       str_req,
    output logic [lsu_pkg::addr_w-1:0] str_addr,
    output logic [lsu_pkg::data_w-1:0] str_data,
    output logic                       str_iss,
    output logic                       stll
);

    import lsu_pkg::*;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } sq_entry_t;

    sq_entry_t        sq_mem [sq_depth];
    sq_entry_t        head_ent;
    logic [ptr_w:0]   head;
    logic [ptr_w:0]   cmt;
    logic [ptr_w:0]   tail;
    logic [ptr_w:0]   cmt_nxt;
    logic [ptr_w:0]   cmt_lag;
    logic [ptr_w-1:0] fwd_dist;
    logic             sq_full;
    logic             sq_wr;
    logic             has_uncmt;
    logic             str_busy;

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////
    // head..cmt committed, cmt..tail still speculative
    assign sq_full   = (head[ptr_w] != tail[ptr_w]) && (head[ptr_w-1:0] == tail[ptr_w-1:0]);
    assign sq_wr     = issue_vld && (issue.op == op_store);
    assign has_uncmt = (cmt != tail);
    assign cmt_nxt   = (cmmt_str && has_uncmt) ? cmt + 1'b1 : cmt;
    assign cmt_lag   = tail - cmt;
    assign head_ent  = sq_mem[head[ptr_w-1:0]];

    assign sq_tail  = tail[ptr_w-1:0];
    assign stll     = sq_full;
    assign str_req  = (head != cmt);
    assign str_addr = head_ent.addr;
    assign str_data = head_ent.data;
    assign str_iss  = str_busy && mem_done;

    always_ff @(posedge clk) begin
        if (sq_wr) begin
            sq_mem[tail[ptr_w-1:0]] <= '{addr: issue.addr, data: issue.data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head     <= '0;
            cmt      <= '0;
            tail     <= '0;
            str_busy <= 1'b0;
        end else begin
            cmt <= cmt_nxt;
            if (flsh) begin
                tail <= cmt_nxt;
            end else if (sq_wr) begin
                tail <= tail + 1'b1;
            end
            if (str_grnt) begin
                str_busy <= 1'b1;
            end
            // Entry leaves once memory has taken the write
            if (str_iss) begin
                head     <= head + 1'b1;
                str_busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////
    // Entries from head up to the snapshot are older, last match is youngest
    assign fwd_dist = fwd_ptr - head[ptr_w-1:0];

    always_comb begin
        logic [ptr_w-1:0] idx;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int i = 0; i < sq_depth; i++) begin
            idx = head[ptr_w-1:0] + ptr_w'(i);
            if ((i < fwd_dist) && (sq_mem[idx].addr == fwd_addr)) begin
                fwd_hit  = 1'b1;
                fwd_data = sq_mem[idx].data;
            end
        end
    end

    // Commit and flush together must keep cmt between head and tail
    assert property (@(posedge clk) disable iff (!rst_n)
        cmt_lag <= (ptr_w + 1)'(sq_depth));

endmodule

/* hw/load_store_arbiter.sv */
`timescale 1ns/1ns

module load_store_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ld_req,
    input  logic                       str_req,
    input  logic                       mem_idle,
    input  logic                       mem_done,
    input  logic [lsu_pkg::addr_w-1:0] ld_addr,
    input  logic [lsu_pkg::addr_w-1:0] str_addr,
    input  logic [lsu_pkg::data_w-1:0] str_data,
    output logic                       ld_grnt,
    output logic                       str_grnt,
    output logic                       mem_en,
    output lsu_pkg::mem_req_t          mem_req
);

    import lsu_pkg::*;

    arb_state_e state;
    arb_state_e state_nxt;
    logic       prio_str;

    always_comb begin
        state_nxt = state;
        case (state)
            arb_idle: begin
                if (mem_idle) begin
                    if (str_req && (prio_str || !ld_req)) begin
                        state_nxt = arb_store;
                    end else if (ld_req) begin
                        state_nxt = arb_load;
                    end
                end
            end
            arb_load, arb_store: state_nxt = arb_wait;
            arb_wait: begin
                if (mem_done) begin
                    state_nxt = arb_idle;
                end
            end
            default: state_nxt = arb_idle;
        endcase
    end

    // Stores win the first tie after reset, then turns alternate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= arb_idle;
            prio_str <= 1'b1;
        end else begin
            state <= state_nxt;
            if (state == arb_load) begin
                prio_str <= 1'b1;
            end else if (state == arb_store) begin
                prio_str <= 1'b0;
            end
        end
    end

    assign ld_grnt  = (state == arb_load);
    assign str_grnt = (state == arb_store);
    assign mem_en   = ld_grnt || str_grnt;

    always_comb begin
        mem_req.rd_wrt = str_grnt;
        mem_req.addr   = str_grnt ? str_addr : ld_addr;
        mem_req.data   = str_data;
    end

    // Grants never overlap and memory answers only the access in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        !(ld_grnt && str_grnt) && (!mem_done || (state == arb_wait)));

endmodule

/* hw/memory_system.sv */
`timescale 1ns/1ns

module memory_system (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       mem_en,
    input  lsu_pkg::mem_req_t          mem_req,
    output logic                       mem_idle,
    output logic                       mem_done,
    output logic [lsu_pkg::data_w-1:0] rd_data
);

    import lsu_pkg::*;

    logic [data_w-1:0] ram [2**addr_w];
    mem_req_t          req_q;
    logic              busy;
    logic              rd_stage;
    logic [lat_w-1:0]  lat_cnt;

    assign mem_idle = !busy;

    // Last counting cycle, data is fetched here for the done cycle
    assign rd_stage = busy && (lat_cnt == 1);

    always_ff @(posedge clk) begin
        if (mem_en) begin
            req_q <= mem_req;
        end
        if (rd_stage) begin
            rd_data <= ram[req_q.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            mem_done <= 1'b0;
            for (int i = 0; i < 2**addr_w; i++) begin
                ram[i] <= '0;
            end
        end else begin
            mem_done <= rd_stage;
            if (mem_en) begin
                busy    <= 1'b1;
                lat_cnt <= lat_w'(mem_latency - 1);
            end else if (busy && (lat_cnt != 0)) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            if (mem_done) begin
                busy <= 1'b0;
                if (req_q.rd_wrt) begin
                    ram[req_q.addr] <= req_q.data;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mem_en |-> mem_idle);

endmodule

/* hw/load_store_unit.sv */
`timescale 1ns/1ns

module load_store_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_vld,
    input  lsu_pkg::lsu_issue_t issue,
    input  logic                cmmt_str,
    input  logic                flsh,
    output logic                stll,
    output lsu_pkg::ld_result_t ld_result,
    output logic                str_iss
);

    import lsu_pkg::*;

    logic              issue_ok;
    logic              stll_ld;
    logic              stll_str;
    logic [ptr_w-1:0]  sq_tail;
    logic [addr_w-1:0] fwd_addr;
    logic [ptr_w-1:0]  fwd_ptr;
    logic              fwd_hit;
    logic [data_w-1:0] fwd_data;
    logic              ld_req;
    logic              ld_grnt;
    logic [addr_w-1:0] ld_addr;
    logic              str_req;
    logic              str_grnt;
    logic [addr_w-1:0] str_addr;
    logic [data_w-1:0] str_data;
    logic              mem_en;
    logic              mem_idle;
    logic              mem_done;
    logic [data_w-1:0] rd_data;
    mem_req_t          mem_req;

    // A full queue on either side holds the whole issue port
    assign stll     = stll_ld | stll_str;
    assign issue_ok = issue_vld && !stll;

    load_queue lq (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue_vld (issue_ok),
        .issue     (issue),
        .flsh      (flsh),
        .sq_tail   (sq_tail),
        .fwd_hit   (fwd_hit),
        .fwd_data  (fwd_data),
        .ld_grnt   (ld_grnt),
        .mem_done  (mem_done),
        .rd_data   (rd_data),
        .fwd_addr  (fwd_addr),
        .fwd_ptr   (fwd_ptr),
        .ld_req    (ld_req),
        .ld_addr   (ld_addr),
        .ld_result (ld_result),
        .stll      (stll_ld)
    );

    store_queue sq (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue_vld (issue_ok),
        .issue     (issue),
        .cmmt_str  (cmmt_str),
        .flsh      (flsh),
        .fwd_addr  (fwd_addr),
        .fwd_ptr   (fwd_ptr),
        .str_grnt  (str_grnt),
        .mem_done  (mem_done),
        .sq_tail   (sq_tail),
        .fwd_hit   (fwd_hit),
        .fwd_data  (fwd_data),
        .str_req   (str_req),
        .str_addr  (str_addr),
        .str_data  (str_data),
        .str_iss   (str_iss),
        .stll      (stll_str)
    );

    load_store_arbiter lsa (
        .clk      (clk),
        .rst_n    (rst_n),
        .ld_req   (ld_req),
        .str_req  (str_req),
        .mem_idle (mem_idle),
        .mem_done (mem_done),
        .ld_addr  (ld_addr),
        .str_addr (str_addr),
        .str_data (str_data),
        .ld_grnt  (ld_grnt),
        .str_grnt (str_grnt),
        .mem_en   (mem_en),
        .mem_req  (mem_req)
    );

    memory_system mem_sys (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_en   (mem_en),
        .mem_req  (mem_req),
        .mem_idle (mem_idle),
        .mem_done (mem_done),
        .rd_data  (rd_data)
    );

endmodule

/* verif/lsu_checker.sv */
`timescale 1ns/1ns

module lsu_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  lsu_pkg::ld_result_t ld_result,
    input  logic                str_iss,
    input  logic                stll,
    input  logic                exp_vld,
    input  lsu_pkg::ld_result_t exp_ld,
    input  int                  cmt_cnt,
    output int                  err_cnt,
    output logic                drained,
    output logic                stll_seen
);

    import lsu_pkg::*;

    ld_result_t exp_q[$];
    ld_result_t exp_head;
    int         iss_cnt;

    // DUT outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            iss_cnt   = 0;
            err_cnt   = 0;
            drained   = 1'b1;
            stll_seen = 1'b0;
        end else begin
            if (exp_vld) begin
                exp_q.push_back(exp_ld);
            end

            ////////////////////////////////////////
            // Load results, oldest load first
            ////////////////////////////////////////
            if (ld_result.vld) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t ns: load result with tag %0d but no load outstanding",
                             $time, ld_result.tag);
                    err_cnt++;
                end else begin
                    exp_head = exp_q.pop_front();
                    if (ld_result.tag !== exp_head.tag) begin
                        $display("MISMATCH at %0t ns: ld_result.tag expected %0d got %0d",
                                 $time, exp_head.tag, ld_result.tag);
                        err_cnt++;
                    end
                    if (ld_result.data !== exp_head.data) begin
                        $display("MISMATCH at %0t ns: ld_result.data expected %h got %h",
                                 $time, exp_head.data, ld_result.data);
                        err_cnt++;
                    end
                end
            end

            // A store may only retire after its commit
            if (str_iss) begin
                if (iss_cnt >= cmt_cnt) begin
                    $display("ERROR at %0t ns: store retired without a matching commit", $time);
                    err_cnt++;
                end
                iss_cnt++;
            end

            if (stll) begin
                stll_seen = 1'b1;
            end
            drained = (exp_q.size() == 0) && (iss_cnt == cmt_cnt);
        end
    end

endmodule

/* verif/lsu_tb.sv */
`timescale 1ns/1ns

module lsu_tb;

    import lsu_pkg::*;

    localparam int stall_limit = 200;
    localparam int drain_limit = 1000;

    logic       clk;
    logic       rst_n;
    logic       issue_vld;
    lsu_issue_t issue;
    logic       cmmt_str;
    logic       flsh;
    logic       stll;
    ld_result_t ld_result;
    logic       str_iss;
    logic       exp_vld;
    ld_result_t exp_ld;
    int         cmt_cnt;
    int         chk_err;
    int         tb_err;
    logic       drained;
    logic       stll_seen;

    load_store_unit u_load_store_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue_vld (issue_vld),
        .issue     (issue),
        .cmmt_str  (cmmt_str),
        .flsh      (flsh),
        .stll      (stll),
        .ld_result (ld_result),
        .str_iss   (str_iss)
    );

    lsu_checker u_lsu_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_result (ld_result),
        .str_iss   (str_iss),
        .stll      (stll),
        .exp_vld   (exp_vld),
        .exp_ld    (exp_ld),
        .cmt_cnt   (cmt_cnt),
        .err_cnt   (chk_err),
        .drained   (drained),
        .stll_seen (stll_seen)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////
    // Inputs move 1 ns after the rising edge, pulses last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        issue_vld = 1'b0;
        cmmt_str  = 1'b0;
        flsh      = 1'b0;
        exp_vld   = 1'b0;
    endtask

    task automatic wait_issue_slot();
        int waited;
        waited = 0;
        next_cycle();
        while (stll && (waited < stall_limit)) begin
            next_cycle();
            waited++;
        end
        if (stll) begin
            $display("ERROR at %0t ns: stll stayed high for %0d cycles", $time, stall_limit);
            tb_err++;
        end
    endtask

    task automatic run_line(input int kind, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] tag, input logic [31:0] exp_word);
        case (kind)
            0, 1: begin
                wait_issue_slot();
                issue_vld = 1'b1;
                issue     = '{op: (kind == 0) ? op_load : op_store, addr: addr[addr_w-1:0],
                              data: data[data_w-1:0], tag: tag[tag_w-1:0]};
                // Expected value wider than the data marks a flushed load
                if ((kind == 0) && (exp_word <= 32'hffff)) begin
                    exp_vld = 1'b1;
                    exp_ld  = '{vld: 1'b1, tag: tag[tag_w-1:0], data: exp_word[data_w-1:0]};
                end
            end
            2: begin
                next_cycle();
                cmmt_str = 1'b1;
                cmt_cnt++;
            end
            3: begin
                next_cycle();
                flsh = 1'b1;
            end
            4: repeat (addr) next_cycle();
            default: begin
                $display("ERROR: unknown operation kind %0d in the stimulus file", kind);
                tb_err++;
            end
        endcase
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int          fd;
        int          n;
        int          kind;
        int          waited;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] tag;
        logic [31:0] exp_word;
        string       line;

        rst_n     = 1'b0;
        issue_vld = 1'b0;
        issue     = '0;
        cmmt_str  = 1'b0;
        flsh      = 1'b0;
        exp_vld   = 1'b0;
        exp_ld    = '0;
        cmt_cnt   = 0;
        tb_err    = 0;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("verif/lsu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open verif/lsu_stimulus.txt for reading");
            tb_err++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines do not yield five fields
                if ((n > 0) &&
                    ($sscanf(line, "%d %h %h %h %h", kind, addr, data, tag, exp_word) == 5)) begin
                    run_line(kind, addr, data, tag, exp_word);
                end
            end
            $fclose(fd);
        end
        next_cycle();

        waited = 0;
        while (!drained && (waited < drain_limit)) begin
            next_cycle();
            waited++;
        end
        if (!drained) begin
            $display("ERROR: load results or store retirements missing after %0d cycles",
                     drain_limit);
            tb_err++;
        end
        if (!stll_seen) begin
            $display("ERROR: stll never rose, so the queues were never filled");
            tb_err++;
        end

        $display("Error counts: checker %0d, testbench %0d", chk_err, tb_err);
        if ((chk_err == 0) && (tb_err == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verif/lsu_stimulus.txt */
// kind addr data tag expected, hex except kind; 0 load, 1 store, 2 commit, 3 flush, 4 idle
// kind 4 waits addr cycles; expected 10000 marks a load removed by the flush after it
0 10 0000 01 0000
1 20 1111 00 0000
0 20 0000 02 1111
1 20 2222 00 0000
0 20 0000 03 2222
4 20 0000 00 0000
2 00 0000 00 0000
2 00 0000 00 0000
4 20 0000 00 0000
0 20 0000 04 2222
4 20 0000 00 0000
1 30 3333 00 0000
2 00 0000 00 0000
4 20 0000 00 0000
1 30 4444 00 0000
0 30 0000 05 10000
3 00 0000 00 0000
0 30 0000 06 3333
4 20 0000 00 0000
1 40 5555 00 0000
1 41 6666 00 0000
2 00 0000 00 0000
2 00 0000 00 0000
0 40 0000 07 5555
0 41 0000 08 6666
0 20 0000 09 2222
0 30 0000 0a 3333
0 42 0000 0b 0000
0 43 0000 0c 0000
0 44 0000 0d 0000
0 45 0000 0e 0000
0 46 0000 0f 0000
0 47 0000 10 0000
0 48 0000 11 0000
0 10 0000 12 0000

/* list.f */
hw/lsu_pkg.sv
hw/load_queue.sv
hw/store_queue.sv
hw/load_store_arbiter.sv
hw/memory_system.sv
hw/load_store_unit.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

/* Makefile */
LOG = sim.log

all: run

obj_dir/Vlsu_tb: list.f $(wildcard hw/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f list.f

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module load_store_unit -f list.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
